// ==== common/la_pkg.sv ====
/* la_pkg: alu op, operand select and exception enums,
   plus the instruction word union used by the decoder */
package la_pkg;

    ////////////////////////////////////////////////////////////
    // control encodings

    // register-form codes match inst[18:15] of add.w .. srl.w
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd2,
        alu_slt  = 4'd4,
        alu_sltu = 4'd5,
        alu_sra  = 4'd7,     // free slot, sra.w has its own opcode
        alu_nor  = 4'd8,
        alu_and  = 4'd9,
        alu_or   = 4'd10,
        alu_xor  = 4'd11,
        alu_sll  = 4'd14,
        alu_srl  = 4'd15
    } alu_op_e;

    typedef enum logic [1:0] {
        src1_rf   = 2'd0,
        src1_zero = 2'd1,    // lu12i.w
        src1_pc   = 2'd2     // pcaddu12i
    } src1_e;

    typedef enum logic {
        src2_rf  = 1'b0,
        src2_imm = 1'b1
    } src2_e;

    typedef enum logic [1:0] {
        exc_none = 2'd0,
        exc_ine  = 2'd1,     // instruction not exist
        exc_sys  = 2'd2,
        exc_brk  = 2'd3
    } exc_e;

    ////////////////////////////////////////////////////////////
    // instruction word, viewed per format

    typedef union packed {
        struct packed {
            logic [16:0] opcode17;
            logic [4:0]  rk;     // also ui5 of the shift forms
            logic [4:0]  rj;
            logic [4:0]  rd;
        } r3;
        struct packed {
            logic [9:0]  opcode10;
            logic [11:0] imm12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri12;
        struct packed {
            logic [6:0]  opcode7;
            logic [19:0] imm20;
            logic [4:0]  rd;
        } ri20;
    } inst_u;

endpackage

// ==== common/dec_exe_if.sv ====
/* dec_exe_if: decoded instruction bundle, decode register to execute */
`timescale 1ns/1ps
interface dec_exe_if;
    import la_pkg::*;

    logic        valid;      // qualifies every field below
    alu_op_e     op;
    src1_e       src1;
    src2_e       src2;
    logic [4:0]  rd;         // zero when nothing is written
    logic [31:0] rj_val;     // already bypassed
    logic [31:0] rk_val;
    logic [31:0] imm;
    logic [31:0] pc;
    exc_e        exc;

    modport dec (output valid, op, src1, src2, rd, rj_val, rk_val, imm, pc, exc);
    modport exe (input  valid, op, src1, src2, rd, rj_val, rk_val, imm, pc, exc);

endinterface

// ==== decode/la_decoder.sv ====
/* la_decoder: combinational la32 decode into alu op, operand selects,
   register numbers, immediate and exception code */
`timescale 1ns/1ps
module la_decoder (
    input  logic [31:0]     inst,
    output la_pkg::alu_op_e op,
    output la_pkg::src1_e   src1,
    output la_pkg::src2_e   src2,
    output logic [4:0]      rd,
    output logic [4:0]      rj,
    output logic [4:0]      rk,
    output logic [31:0]     imm,
    output la_pkg::exc_e    exc
);
    import la_pkg::*;

    inst_u w;                // same word, three views
    assign w = inst;

    ////////////////////////////////////////////////////////////
    // group match

    logic is_alu3;           // add.w .. srl.w, op sits in inst[18:15]
    logic is_sra3;           // sra.w, outside that block
    logic is_sfti;           // slli.w srli.w srai.w
    logic is_imm12;          // slti sltui addi.w andi ori xori
    logic is_lu12i;
    logic is_pcadd;
    logic is_sys;
    logic is_brk;
    logic op_ok;             // sub-op of a matched group exists
    logic kept;

    assign is_alu3  = w.r3.opcode17[16:4] == 13'h002;
    assign is_sra3  = w.r3.opcode17 == 17'h00030;
    assign is_sfti  = w.r3.opcode17[16:5] == 12'h004 && w.r3.opcode17[2:0] == 3'b001;
    assign is_imm12 = w.ri12.opcode10[9:3] == 7'h01;
    assign is_lu12i = w.ri20.opcode7 == 7'h0a;
    assign is_pcadd = w.ri20.opcode7 == 7'h0e;
    assign is_sys   = w.r3.opcode17 == 17'h00056;
    assign is_brk   = w.r3.opcode17 == 17'h00054;  // inst[16] tells them apart

    ////////////////////////////////////////////////////////////
    // alu op

    always_comb begin
        op    = alu_add;     // upper immediates add too, src1 does the rest
        op_ok = 1'b1;
        if (is_alu3) begin
            case (w.r3.opcode17[3:0])
                4'd0, 4'd2, 4'd4, 4'd5, 4'd8, 4'd9, 4'd10, 4'd11, 4'd14, 4'd15:
                    op = alu_op_e'(w.r3.opcode17[3:0]);
                default:
                    op_ok = 1'b0;    // add.d, maskeqz, orn and friends
            endcase
        end else if (is_sra3) begin
            op = alu_sra;
        end else if (is_sfti) begin
            case (w.r3.opcode17[4:3])    // inst[19:18]
                2'b00:   op = alu_sll;
                2'b01:   op = alu_srl;
                2'b10:   op = alu_sra;
                default: op_ok = 1'b0;
            endcase
        end else if (is_imm12) begin
            case (w.ri12.opcode10[2:0])  // inst[24:22]
                3'b000:  op = alu_slt;
                3'b001:  op = alu_sltu;
                3'b010:  op = alu_add;
                3'b101:  op = alu_and;
                3'b110:  op = alu_or;
                3'b111:  op = alu_xor;
                default: op_ok = 1'b0;  // addi.d, lu52i.d
            endcase
        end
    end

    assign kept = (is_alu3 || is_sra3 || is_sfti || is_imm12 || is_lu12i || is_pcadd)
                  && op_ok;

    assign exc = is_sys ? exc_sys :
                 is_brk ? exc_brk :
                 kept   ? exc_none : exc_ine;

    ////////////////////////////////////////////////////////////
    // operands and registers

    assign src1 = is_lu12i ? src1_zero : is_pcadd ? src1_pc : src1_rf;
    assign src2 = (is_sfti || is_imm12 || is_lu12i || is_pcadd) ? src2_imm : src2_rf;

    assign rd = (exc == exc_none) ? w.r3.rd : 5'd0;   // faults write r0, i.e. nothing
    assign rj = (exc == exc_none && !is_lu12i && !is_pcadd) ? w.r3.rj : 5'd0;
    assign rk = (is_alu3 || is_sra3) ? w.r3.rk : 5'd0;

    always_comb begin
        if (is_lu12i || is_pcadd) begin
            imm = {w.ri20.imm20, 12'd0};                   // si20 << 12
        end else if (is_sfti) begin
            imm = {27'd0, w.r3.rk};                        // ui5
        end else if (is_imm12 && w.ri12.opcode10[2]) begin
            imm = {20'd0, w.ri12.imm12};                   // andi ori xori, u12
        end else begin
            imm = {{20{w.ri12.imm12[11]}}, w.ri12.imm12};  // si12
        end
    end

endmodule

// ==== decode/decode_stage.sv ====
/* decode_stage: decoder, register reads with bypass, decode register */
`timescale 1ns/1ps
module decode_stage (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    output logic [4:0]  raddr_j,
    output logic [4:0]  raddr_k,
    input  logic [31:0] rdata_j,
    input  logic [31:0] rdata_k,
    input  logic        exe_fwd_valid,
    input  logic [4:0]  exe_fwd_rd,
    input  logic [31:0] exe_fwd_data,
    input  logic        res_valid,
    input  logic [4:0]  res_rd,
    input  logic [31:0] res_data,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    dec_exe_if.dec      dex
);
    import la_pkg::*;

    alu_op_e     dec_op;
    src1_e       dec_src1;
    src2_e       dec_src2;
    logic [4:0]  dec_rd;
    logic [31:0] dec_imm;
    exc_e        dec_exc;

    la_decoder la_decoder_inst (
        .inst (inst),
        .op   (dec_op),
        .src1 (dec_src1),
        .src2 (dec_src2),
        .rd   (dec_rd),
        .rj   (raddr_j),
        .rk   (raddr_k),
        .imm  (dec_imm),
        .exc  (dec_exc)
    );

    ////////////////////////////////////////////////////////////
    // bypass, youngest producer wins

    function automatic logic [31:0] bypass(input logic [4:0] addr, input logic [31:0] rf_val);
        logic [31:0] val;
        val = rf_val;
        if (addr != 5'd0) begin
            if (exe_fwd_valid && exe_fwd_rd == addr)
                val = exe_fwd_data;                  // one ahead, not registered yet
            else if (res_valid && res_rd == addr)
                val = res_data;                      // two ahead
            else if (we && waddr == addr)
                val = wdata;                         // written at this edge
        end
        return val;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dex.valid <= 1'b0;
        end else begin
            dex.valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin        // payload only, held when idle
            dex.op     <= dec_op;
            dex.src1   <= dec_src1;
            dex.src2   <= dec_src2;
            dex.rd     <= dec_rd;
            dex.rj_val <= bypass(raddr_j, rdata_j);
            dex.rk_val <= bypass(raddr_k, rdata_k);
            dex.imm    <= dec_imm;
            dex.pc     <= pc;
            dex.exc    <= dec_exc;
        end
    end

endmodule

// ==== source/reg_file.sv ====
/* reg_file: 32 x 32 general registers, r0 tied to zero */
`timescale 1ns/1ps
module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [4:0]  raddr_j,
    input  logic [4:0]  raddr_k,
    output logic [31:0] rdata_j,
    output logic [31:0] rdata_k
);
    logic [31:0] regs [0:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && waddr != 5'd0) begin   // r0 never written
            regs[waddr] <= wdata;
        end
    end

    // async reads, same-edge write is covered by bypass upstream
    assign rdata_j = (raddr_j == 5'd0) ? 32'd0 : regs[raddr_j];
    assign rdata_k = (raddr_k == 5'd0) ? 32'd0 : regs[raddr_k];

endmodule

// ==== source/alu_execute.sv ====
/* alu_execute: operand select, alu, execute register */
`timescale 1ns/1ps
module alu_execute (
    input  logic         clk,
    input  logic         rst_n,
    dec_exe_if.exe       dex,
    output logic         exe_fwd_valid,
    output logic [4:0]   exe_fwd_rd,
    output logic [31:0]  exe_fwd_data,
    output logic         res_valid,
    output logic [4:0]   res_rd,
    output logic [31:0]  res_data,
    output la_pkg::exc_e res_exc,
    output logic [31:0]  res_pc
);
    import la_pkg::*;

    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] result;

    always_comb begin
        case (dex.src1)
            src1_zero: op1 = 32'd0;          // lu12i.w
            src1_pc:   op1 = dex.pc;         // pcaddu12i
            default:   op1 = dex.rj_val;
        endcase
    end

    assign op2 = (dex.src2 == src2_imm) ? dex.imm : dex.rk_val;

    always_comb begin
        case (dex.op)
            alu_sub:  result = op1 - op2;
            alu_slt:  result = {31'd0, $signed(op1) < $signed(op2)};
            alu_sltu: result = {31'd0, op1 < op2};
            alu_nor:  result = ~(op1 | op2);
            alu_and:  result = op1 & op2;
            alu_or:   result = op1 | op2;
            alu_xor:  result = op1 ^ op2;
            alu_sll:  result = op1 << op2[4:0];    // only low 5 bits shift
            alu_srl:  result = op1 >> op2[4:0];
            alu_sra:  result = $signed(op1) >>> op2[4:0];
            default:  result = op1 + op2;        // add, upper immediates
        endcase
    end

    // forward to decode before the register
    assign exe_fwd_valid = dex.valid && dex.exc == exc_none;
    assign exe_fwd_rd    = dex.rd;
    assign exe_fwd_data  = result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= dex.valid;
        end
    end

    always_ff @(posedge clk) begin
        res_rd   <= dex.rd;
        res_data <= result;
        res_exc  <= dex.exc;
        res_pc   <= dex.pc;
    end

endmodule

// ==== source/retire.sv ====
/* retire: result register, split into writeback or exception report */
`timescale 1ns/1ps
module retire (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         res_valid,
    input  logic [4:0]   res_rd,
    input  logic [31:0]  res_data,
    input  la_pkg::exc_e res_exc,
    input  logic [31:0]  res_pc,
    output logic         we,
    output logic [4:0]   waddr,
    output logic [31:0]  wdata,
    output logic         wb_valid,
    output logic [4:0]   wb_rd,
    output logic [31:0]  wb_data,
    output logic         exc_valid,
    output la_pkg::exc_e exc_code,
    output logic [31:0]  exc_pc
);
    import la_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid  <= 1'b0;
            exc_valid <= 1'b0;
        end else begin
            wb_valid  <= res_valid && res_exc == exc_none && res_rd != 5'd0;
            exc_valid <= res_valid && res_exc != exc_none;   // faults never write
        end
    end

    always_ff @(posedge clk) begin
        wb_rd    <= res_rd;
        wb_data  <= res_data;
        exc_code <= res_exc;
        exc_pc   <= res_pc;
    end

    // rf write port mirrors wb_*
    assign we    = wb_valid;
    assign waddr = wb_rd;
    assign wdata = wb_data;

endmodule

// ==== source/la_int_core.sv ====
/* la_int_core: top level, decode / execute / retire and the register file */
`timescale 1ns/1ps
module la_int_core (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data,
    output logic        exc_valid,
    output logic [1:0]  exc_code,
    output logic [31:0] exc_pc
);
    import la_pkg::*;

    logic [4:0]  raddr_j;
    logic [4:0]  raddr_k;
    logic [31:0] rdata_j;
    logic [31:0] rdata_k;
    logic        exe_fwd_valid;    // execute result, combinational
    logic [4:0]  exe_fwd_rd;
    logic [31:0] exe_fwd_data;
    logic        res_valid;        // execute register
    logic [4:0]  res_rd;
    logic [31:0] res_data;
    exc_e        res_exc;
    logic [31:0] res_pc;
    logic        we;               // retire register, rf write port
    logic [4:0]  waddr;
    logic [31:0] wdata;

    dec_exe_if dex ();

    decode_stage decode_stage_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .pc            (pc),
        .raddr_j       (raddr_j),
        .raddr_k       (raddr_k),
        .rdata_j       (rdata_j),
        .rdata_k       (rdata_k),
        .exe_fwd_valid (exe_fwd_valid),
        .exe_fwd_rd    (exe_fwd_rd),
        .exe_fwd_data  (exe_fwd_data),
        .res_valid     (res_valid),
        .res_rd        (res_rd),
        .res_data      (res_data),
        .we            (we),
        .waddr         (waddr),
        .wdata         (wdata),
        .dex           (dex.dec)
    );

    reg_file reg_file_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (we),
        .waddr   (waddr),
        .wdata   (wdata),
        .raddr_j (raddr_j),
        .raddr_k (raddr_k),
        .rdata_j (rdata_j),
        .rdata_k (rdata_k)
    );

    alu_execute alu_execute_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .dex           (dex.exe),
        .exe_fwd_valid (exe_fwd_valid),
        .exe_fwd_rd    (exe_fwd_rd),
        .exe_fwd_data  (exe_fwd_data),
        .res_valid     (res_valid),
        .res_rd        (res_rd),
        .res_data      (res_data),
        .res_exc       (res_exc),
        .res_pc        (res_pc)
    );

    retire retire_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_valid (res_valid),
        .res_rd    (res_rd),
        .res_data  (res_data),
        .res_exc   (res_exc),
        .res_pc    (res_pc),
        .we        (we),
        .waddr     (waddr),
        .wdata     (wdata),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .exc_valid (exc_valid),
        .exc_code  (exc_code),     // enum out as a plain 2-bit code
        .exc_pc    (exc_pc)
    );

endmodule

// ==== sim/la_ref_model.svh ====
/* reference model: model register file, reset and a task that decodes
   and executes one instruction word in program order */
`ifndef la_ref_model_svh
`define la_ref_model_svh

logic [31:0] model_rf [0:31];    // r0 is never written, stays zero

task automatic model_reset();
    for (int i = 0; i < 32; i++) begin
        model_rf[i] = 32'd0;
    end
endtask

// one word, executed at once, so later words see its result
task automatic model_step(
    input  logic [31:0] word,
    input  logic [31:0] pc_val,
    output exc_e        code,
    output logic [4:0]  rd,
    output logic [31:0] val
);
    inst_u       f;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] si12;
    logic [31:0] ui12;
    logic [31:0] hi20;
    f    = word;
    a    = model_rf[f.r3.rj];
    b    = model_rf[f.r3.rk];
    si12 = {{20{f.ri12.imm12[11]}}, f.ri12.imm12};   // slti sltui addi.w
    ui12 = {20'd0, f.ri12.imm12};                    // andi ori xori
    hi20 = {f.ri20.imm20, 12'd0};
    code = exc_none;
    rd   = f.r3.rd;
    val  = 32'd0;

    ////////////////////////////////////////////////////////////
    // opcode match, widest opcode first
    case (f.r3.opcode17)
        17'h00020: val = a + b;                                    // add.w
        17'h00022: val = a - b;                                    // sub.w
        17'h00024: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        17'h00025: val = (a < b) ? 32'd1 : 32'd0;                  // sltu
        17'h00028: val = ~(a | b);                                 // nor
        17'h00029: val = a & b;
        17'h0002a: val = a | b;
        17'h0002b: val = a ^ b;
        17'h0002e: val = a << b[4:0];                              // sll.w
        17'h0002f: val = a >> b[4:0];                              // srl.w
        17'h00030: val = $signed(a) >>> b[4:0];                    // sra.w
        17'h00081: val = a << f.r3.rk;                             // slli.w, ui5 in rk slot
        17'h00089: val = a >> f.r3.rk;                             // srli.w
        17'h00091: val = $signed(a) >>> f.r3.rk;                   // srai.w
        17'h00056: code = exc_sys;
        17'h00054: code = exc_brk;
        default: begin
            case (f.ri12.opcode10)
                10'h008: val = ($signed(a) < $signed(si12)) ? 32'd1 : 32'd0;
                10'h009: val = (a < si12) ? 32'd1 : 32'd0;         // sltui
                10'h00a: val = a + si12;                           // addi.w
                10'h00d: val = a & ui12;
                10'h00e: val = a | ui12;
                10'h00f: val = a ^ ui12;
                default: begin
                    case (f.ri20.opcode7)
                        7'h0a:   val = hi20;                       // lu12i.w
                        7'h0e:   val = pc_val + hi20;              // pcaddu12i
                        default: code = exc_ine;
                    endcase
                end
            endcase
        end
    endcase

    if (code != exc_none) begin
        val = pc_val;                // faults report their pc
    end else if (rd != 5'd0) begin
        model_rf[rd] = val;
    end
endtask

`endif

// ==== sim/la_int_core_tb.sv ====
/* la_int_core_tb: clock, reset, random instruction stream,
   expected-result queue compared with the DUT every cycle */
`timescale 1ns/1ps
module la_int_core_tb;
    import la_pkg::*;

    localparam int reset_cycles   = 16;
    localparam int slot_count     = 2000;
    localparam int timeout_cycles = reset_cycles + slot_count + 20;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        exc_valid;
    logic [1:0]  exc_code;
    logic [31:0] exc_pc;

    integer seed;
    int     edge_cnt = 0;        // rising edges so far

    // expected outputs, one entry per writing or faulting word
    int          exp_due[$];     // edge after which the output shows
    string       exp_name[$];
    logic [1:0]  exp_code[$];
    logic [4:0]  exp_rd[$];
    logic [31:0] exp_val[$];     // wb_data, or exc_pc on a fault

    `include "la_ref_model.svh"

    la_int_core la_int_core_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .exc_valid  (exc_valid),
        .exc_code   (exc_code),
        .exc_pc     (exc_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    ////////////////////////////////////////////////////////////
    // error handling

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        if (edge_cnt >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            abort_run();
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus words, mostly kept instructions on r0..r7

    function automatic logic [31:0] make_word();
        logic [31:0] r;
        logic [31:0] v;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        r  = $random(seed);
        v  = $random(seed);
        rd = {2'b00, r[7:5]};
        rj = {2'b00, r[10:8]};
        rk = {2'b00, r[13:11]};
        case (r[4:0])
            5'd0:    return {17'h00020, rk, rj, rd};          // add.w
            5'd1:    return {17'h00022, rk, rj, rd};          // sub.w
            5'd2:    return {17'h00024, rk, rj, rd};          // slt
            5'd3:    return {17'h00025, rk, rj, rd};          // sltu
            5'd4:    return {17'h00028, rk, rj, rd};          // nor
            5'd5:    return {17'h00029, rk, rj, rd};
            5'd6:    return {17'h0002a, rk, rj, rd};
            5'd7:    return {17'h0002b, rk, rj, rd};
            5'd8:    return {17'h0002e, rk, rj, rd};          // sll.w
            5'd9:    return {17'h0002f, rk, rj, rd};
            5'd10:   return {17'h00030, rk, rj, rd};          // sra.w
            5'd11:   return {17'h00081, v[4:0], rj, rd};      // slli.w
            5'd12:   return {17'h00089, v[4:0], rj, rd};
            5'd13:   return {17'h00091, v[4:0], rj, rd};
            5'd14:   return {10'h008, v[11:0], rj, rd};       // slti
            5'd15:   return {10'h009, v[11:0], rj, rd};       // sltui
            5'd16:   return {10'h00a, v[11:0], rj, rd};       // addi.w
            5'd17:   return {10'h00d, v[11:0], rj, rd};
            5'd18:   return {10'h00e, v[11:0], rj, rd};
            5'd19:   return {10'h00f, v[11:0], rj, rd};
            5'd20:   return {7'h0a, v[19:0], rd};             // lu12i.w
            5'd21:   return {7'h0e, v[19:0], rd};             // pcaddu12i
            5'd22:   return {17'h00056, v[14:0]};             // syscall
            5'd23:   return {17'h00054, v[14:0]};             // break
            5'd24,
            5'd25:   return v;                                // anything at all
            default: return {10'h00a, {7{v[4]}}, v[4:0], rj, rd};  // small addi.w
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // output check, sampled mid-cycle

    task automatic compare_head();
        string       name;
        logic [1:0]  code;
        logic [4:0]  rd;
        logic [31:0] val;
        void'(exp_due.pop_front());
        name = exp_name.pop_front();
        code = exp_code.pop_front();
        rd   = exp_rd.pop_front();
        val  = exp_val.pop_front();
        if (code == exc_none) begin
            check_value({name, " wb_valid"}, 32'd1, wb_valid);
            check_value({name, " exc_valid"}, 32'd0, exc_valid);
            check_value({name, " wb_rd"}, rd, wb_rd);
            check_value({name, " wb_data"}, val, wb_data);
        end else begin
            check_value({name, " exc_valid"}, 32'd1, exc_valid);
            check_value({name, " wb_valid"}, 32'd0, wb_valid);   // faults write nothing
            check_value({name, " exc_code"}, code, exc_code);
            check_value({name, " exc_pc"}, val, exc_pc);
        end
    endtask

    always @(negedge clk) begin
        if (exp_due.size() != 0 && exp_due[0] == edge_cnt) begin
            compare_head();
        end else begin
            check_value("idle wb_valid", 32'd0, wb_valid);     // also covers reset
            check_value("idle exc_valid", 32'd0, exc_valid);
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        logic [31:0] draw;
        logic [31:0] word;
        logic [31:0] next_pc;
        exc_e        code;
        logic [4:0]  rd;
        logic [31:0] val;
        seed       = 32'h904c5ff7;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = 32'd0;
        pc         = 32'd0;
        next_pc    = 32'h1c00_0000;
        model_reset();
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (int slot = 0; slot < slot_count; slot++) begin
            @(posedge clk);
            #2;
            draw = $random(seed);
            if (draw % 5 != 0) begin                   // about 80 percent busy
                word       = make_word();
                inst_valid = 1'b1;
                inst       = word;
                pc         = next_pc;
                model_step(word, next_pc, code, rd, val);
                if (code != exc_none || rd != 5'd0) begin
                    exp_due.push_back(edge_cnt + 3);   // sampled next edge, out 3 edges on
                    exp_name.push_back($sformatf("inst %h pc %h", word, next_pc));
                    exp_code.push_back(code);
                    exp_rd.push_back(rd);
                    exp_val.push_back(val);
                end
                next_pc = next_pc + 32'd4;
            end else begin
                inst_valid = 1'b0;
                inst       = $random(seed);            // garbage, must be ignored
                pc         = $random(seed);
            end
        end

        @(posedge clk);
        #2;
        inst_valid = 1'b0;
        while (exp_due.size() != 0) @(negedge clk);
        repeat (3) @(negedge clk);                     // outputs stay quiet
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== la_int_core.f ====
+incdir+sim
common/la_pkg.sv
common/dec_exe_if.sv
decode/la_decoder.sv
decode/decode_stage.sv
source/reg_file.sv
source/alu_execute.sv
source/retire.sv
source/la_int_core.sv
sim/la_int_core_tb.sv
